//--- rtl/countdown_timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "stopwatch_defines.svh"

module countdown_timer (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              tick,
    input  wire stopwatch_pkg::counter_cmd_t cmd,
    input  wire stopwatch_pkg::sw_time_t     start_time,
    output stopwatch_pkg::sw_time_t          down_time,
    output logic                             done
);

    logic                    running;
    logic                    is_zero;
    logic                    is_last;
    stopwatch_pkg::sw_time_t time_dec;

    assign is_zero = (down_time == '0);
    // Final hundredth before expiry
    assign is_last = (down_time.minutes == '0) && (down_time.seconds == '0) &&
                     (down_time.centi == `SW_CENTI_W'(1));

    ////////////////////////////////////////////////////////////
    // One hundredth back with borrows
    ////////////////////////////////////////////////////////////

    always_comb begin
        time_dec = down_time;
        if (down_time.centi != '0) begin
            time_dec.centi = down_time.centi - `SW_CENTI_W'(1);
        end else begin
            time_dec.centi = `SW_CENTI_W'(`SW_MAX_CENTI);
            if (down_time.seconds != '0) begin
                time_dec.seconds = down_time.seconds - `SW_SEC_W'(1);
            end else begin
                time_dec.seconds = `SW_SEC_W'(`SW_MAX_SEC);
                time_dec.minutes = down_time.minutes - `SW_MIN_W'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running   <= 1'b0;
            done      <= 1'b0;
            down_time <= '0;
        end else if (cmd.restart) begin
            running   <= 1'b0;
            done      <= 1'b0;
            down_time <= start_time;              // Load and wait for start
        end else begin
            done <= 1'b0;
            if (cmd.toggle)
                running <= !running;
            if (tick && running) begin
                if (is_zero) begin
                    running <= 1'b0;              // Restarted at zero, nothing to count
                end else begin
                    down_time <= time_dec;
                    if (is_last) begin
                        running <= 1'b0;
                        done    <= 1'b1;
                    end
                end
            end
        end
    end

    a_done_at_zero: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> (down_time == '0))
        else $error("done while down_time is not zero");

endmodule

`default_nettype wire

//--- rtl/display_select.sv
`timescale 1ns/1ns
`default_nettype none

module display_select (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire stopwatch_pkg::sw_mode_t mode,
    input  wire stopwatch_pkg::sw_time_t program_time,
    input  wire stopwatch_pkg::sw_time_t up_time,
    input  wire stopwatch_pkg::sw_time_t down_time,
    input  wire                          done,
    output stopwatch_pkg::sw_time_t      time_out,
    output logic                         expired
);

    stopwatch_pkg::sw_time_t shown;

    // Time to show for the current mode
    always_comb begin
        case (mode)
            stopwatch_pkg::MODE_PROGRAM: shown = program_time;
            stopwatch_pkg::MODE_UP:      shown = up_time;
            stopwatch_pkg::MODE_DOWN:    shown = down_time;
            default:                     shown = '0;     // Unused encoding
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            time_out <= '0;
            expired  <= 1'b0;
        end else begin
            time_out <= shown;
            expired  <= done;         // Lines up with the zero on time_out
        end
    end

    // The countdown must never hold done high
    a_expired_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        expired |=> !expired)
        else $error("expired held for more than one cycle");

endmodule

`default_nettype wire

//--- rtl/mode_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "stopwatch_defines.svh"

module mode_control (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire stopwatch_pkg::sw_buttons_t buttons,
    output stopwatch_pkg::sw_mode_t     mode,
    output stopwatch_pkg::counter_cmd_t up_cmd,
    output stopwatch_pkg::counter_cmd_t down_cmd,
    output stopwatch_pkg::sw_time_t     program_time,
    output stopwatch_pkg::sw_time_t     down_start
);

    localparam stopwatch_pkg::sw_time_t default_time = '{
        minutes: `SW_MIN_W'(`SW_DEFAULT_MIN),
        seconds: `SW_SEC_W'(`SW_DEFAULT_SEC),
        centi:   '0
    };

    stopwatch_pkg::sw_mode_t     mode_next;
    logic                        mode_change;
    stopwatch_pkg::counter_cmd_t up_cmd_next;
    stopwatch_pkg::counter_cmd_t down_cmd_next;
    stopwatch_pkg::sw_time_t     prog_next;

    ////////////////////////////////////////////////////////////
    // Mode decode and command routing
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (buttons.prog) begin
            mode_next = stopwatch_pkg::MODE_PROGRAM;
        end else if (buttons.count_up) begin
            mode_next = stopwatch_pkg::MODE_UP;
        end else begin
            mode_next = stopwatch_pkg::MODE_DOWN;
        end
    end

    assign mode_change = (mode_next != mode);

    always_comb begin
        up_cmd_next   = '0;
        down_cmd_next = '0;
        if (mode_change) begin                       // Both counters back to their start
            up_cmd_next.restart   = 1'b1;
            down_cmd_next.restart = 1'b1;
        end else if (mode_next == stopwatch_pkg::MODE_UP) begin
            up_cmd_next.toggle  = buttons.start_stop;
            up_cmd_next.restart = buttons.clear;
        end else if (mode_next == stopwatch_pkg::MODE_DOWN) begin
            down_cmd_next.toggle  = buttons.start_stop;
            down_cmd_next.restart = buttons.clear;
        end
    end

    ////////////////////////////////////////////////////////////
    // Programmed countdown time
    ////////////////////////////////////////////////////////////

    always_comb begin
        prog_next = program_time;
        if (mode_next == stopwatch_pkg::MODE_PROGRAM) begin
            if (buttons.clear) begin
                prog_next = '0;
            end else if (buttons.inc) begin
                if (buttons.minute) begin
                    if (program_time.minutes < `SW_MIN_W'(`SW_MAX_MIN))
                        prog_next.minutes = program_time.minutes + `SW_MIN_W'(1);
                end else begin
                    if (program_time.seconds < `SW_SEC_W'(`SW_MAX_SEC))
                        prog_next.seconds = program_time.seconds + `SW_SEC_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode         <= stopwatch_pkg::MODE_PROGRAM;
            up_cmd       <= '0;
            down_cmd     <= '0;
            program_time <= '0;
            down_start   <= '0;
        end else begin
            mode         <= mode_next;
            up_cmd       <= up_cmd_next;
            down_cmd     <= down_cmd_next;
            program_time <= prog_next;
            // Fall back to the built-in time when nothing is programmed
            down_start   <= (prog_next != '0) ? prog_next : default_time;
        end
    end

    // A button reaches one counter only, both restart only on a mode change
    a_cmd_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(up_cmd.toggle && down_cmd.toggle) &&
        ((up_cmd.restart && down_cmd.restart) -> $changed(mode)))
        else $error("up_cmd and down_cmd active together");

endmodule

`default_nettype wire

//--- rtl/stopwatch_defines.svh
`ifndef STOPWATCH_DEFINES_SVH
`define STOPWATCH_DEFINES_SVH

////////////////////////////////////////////////////////////
// Field widths of the time word
////////////////////////////////////////////////////////////

`define SW_MIN_W        6
`define SW_SEC_W        6
`define SW_CENTI_W      7

// Top value of each digit field
`define SW_MAX_MIN      59
`define SW_MAX_SEC      59
`define SW_MAX_CENTI    99

// Built-in countdown time when nothing is programmed
`define SW_DEFAULT_MIN  0
`define SW_DEFAULT_SEC  4

`endif

//--- rtl/stopwatch_pkg.sv
`default_nettype none

`include "stopwatch_defines.svh"

package stopwatch_pkg;

    ////////////////////////////////////////////////////////////
    // Time word
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`SW_MIN_W-1:0]   minutes;   // 0 to 59
        logic [`SW_SEC_W-1:0]   seconds;   // 0 to 59
        logic [`SW_CENTI_W-1:0] centi;     // Hundredths, 0 to 99
    } sw_time_t;

    // Operating mode
    typedef enum logic [1:0] {
        MODE_PROGRAM = 2'd0,
        MODE_UP      = 2'd1,
        MODE_DOWN    = 2'd2
    } sw_mode_t;

    // Buttons are single-cycle pulses, switches are levels
    typedef struct packed {
        logic start_stop;   // Button
        logic clear;        // Button
        logic inc;          // Button
        logic prog;         // Switch, high selects programming
        logic count_up;     // Switch, high counts up
        logic minute;       // Switch, inc steps minutes when high
    } sw_buttons_t;

    // Command to one counter
    typedef struct packed {
        logic restart;
        logic toggle;
    } counter_cmd_t;

endpackage

`default_nettype wire

//--- rtl/stopwatch_top.sv
`timescale 1ns/1ns
`default_nettype none

module stopwatch_top (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire stopwatch_pkg::sw_buttons_t buttons,
    input  wire                             tick,
    output stopwatch_pkg::sw_time_t         time_out,
    output logic                            expired
);

    ////////////////////////////////////////////////////////////
    // Internal connections
    ////////////////////////////////////////////////////////////

    stopwatch_pkg::sw_mode_t     mode;
    stopwatch_pkg::counter_cmd_t up_cmd;
    stopwatch_pkg::counter_cmd_t down_cmd;
    stopwatch_pkg::sw_time_t     program_time;
    stopwatch_pkg::sw_time_t     down_start;
    stopwatch_pkg::sw_time_t     up_time;
    stopwatch_pkg::sw_time_t     down_time;
    logic                        done;

    mode_control mode_control_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .buttons      (buttons),
        .mode         (mode),
        .up_cmd       (up_cmd),
        .down_cmd     (down_cmd),
        .program_time (program_time),
        .down_start   (down_start)
    );

    up_counter up_counter_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .tick    (tick),
        .cmd     (up_cmd),
        .up_time (up_time)
    );

    countdown_timer countdown_timer_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .tick       (tick),
        .cmd        (down_cmd),
        .start_time (down_start),
        .down_time  (down_time),
        .done       (done)
    );

    display_select display_select_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .mode         (mode),
        .program_time (program_time),
        .up_time      (up_time),
        .down_time    (down_time),
        .done         (done),
        .time_out     (time_out),
        .expired      (expired)
    );

endmodule

`default_nettype wire

//--- rtl/up_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "stopwatch_defines.svh"

module up_counter (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              tick,
    input  wire stopwatch_pkg::counter_cmd_t cmd,
    output stopwatch_pkg::sw_time_t          up_time
);

    logic                    running;
    logic                    at_max;
    stopwatch_pkg::sw_time_t time_inc;

    assign at_max = (up_time.minutes == `SW_MIN_W'(`SW_MAX_MIN)) &&
                    (up_time.seconds == `SW_SEC_W'(`SW_MAX_SEC)) &&
                    (up_time.centi   == `SW_CENTI_W'(`SW_MAX_CENTI));

    // One hundredth forward with carries
    always_comb begin
        time_inc = up_time;
        if (up_time.centi == `SW_CENTI_W'(`SW_MAX_CENTI)) begin
            time_inc.centi = '0;
            if (up_time.seconds == `SW_SEC_W'(`SW_MAX_SEC)) begin
                time_inc.seconds = '0;
                time_inc.minutes = up_time.minutes + `SW_MIN_W'(1);  // at_max blocks wrap
            end else begin
                time_inc.seconds = up_time.seconds + `SW_SEC_W'(1);
            end
        end else begin
            time_inc.centi = up_time.centi + `SW_CENTI_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            up_time <= '0;
        end else if (cmd.restart) begin
            running <= 1'b0;
            up_time <= '0;
        end else begin
            if (cmd.toggle)
                running <= !running;
            if (tick && running && !at_max)       // Hold at 59:59.99
                up_time <= time_inc;
        end
    end

    a_fields_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        (up_time.minutes <= `SW_MIN_W'(`SW_MAX_MIN)) &&
        (up_time.seconds <= `SW_SEC_W'(`SW_MAX_SEC)) &&
        (up_time.centi   <= `SW_CENTI_W'(`SW_MAX_CENTI)))
        else $error("up_time field out of range");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the stopwatch testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module stopwatch_tb -f stopwatch_top.f -o stopwatch_sim \
    && ./obj_dir/stopwatch_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- stopwatch_top.f
+incdir+rtl
rtl/stopwatch_pkg.sv
rtl/mode_control.sv
rtl/up_counter.sv
rtl/countdown_timer.sv
rtl/display_select.sv
rtl/stopwatch_top.sv
testbench/stopwatch_tb.sv

//--- testbench/stopwatch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "stopwatch_defines.svh"

module stopwatch_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int CENTI_PER_SEC = `SW_MAX_CENTI + 1;
    localparam int CENTI_PER_MIN = CENTI_PER_SEC * (`SW_MAX_SEC + 1);
    localparam int CENTI_TOP     = (`SW_MAX_MIN + 1) * CENTI_PER_MIN - 1;   // 59:59.99
    localparam int DEFAULT_TICKS =
        (`SW_DEFAULT_MIN * (`SW_MAX_SEC + 1) + `SW_DEFAULT_SEC) * CENTI_PER_SEC;

    // Worst case test length at up to 5 cycles per tick and 6 per press
    localparam int TICK_BUDGET     = (6000 + 1023 + 50) + 240 + (DEFAULT_TICKS + 40) + 600;
    localparam int WATCHDOG_CYCLES = TICK_BUDGET * 5 + 200 * 6 + 500;

    localparam logic [2:0]  PRESS_START = 3'b100;    // {start_stop, clear, inc}
    localparam logic [2:0]  PRESS_CLEAR = 3'b010;
    localparam logic [2:0]  PRESS_INC   = 3'b001;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic                       clk = 1'b0;
    logic                       arst_n;
    logic                       tick;
    stopwatch_pkg::sw_buttons_t buttons;
    stopwatch_pkg::sw_time_t    time_out;
    logic                       expired;

    logic [31:0] lfsr_state = 32'hb378_22b5;
    int          expired_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_start_errors = 0;
    string       cur_test = "";

    stopwatch_top stopwatch_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .buttons  (buttons),
        .tick     (tick),
        .time_out (time_out),
        .expired  (expired)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (arst_n && expired)
            expired_count <= expired_count + 1;    // Every expiry pulse seen
    end

    ////////////////////////////////////////////////////////////
    // Random numbers and the time model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return val;
    endfunction

    // Hundredths to digit fields held at the top value
    function automatic stopwatch_pkg::sw_time_t to_time(input int hundredths);
        stopwatch_pkg::sw_time_t t;
        int h;
        h = (hundredths > CENTI_TOP) ? CENTI_TOP : hundredths;
        t.minutes = `SW_MIN_W'(h / CENTI_PER_MIN);
        t.seconds = `SW_SEC_W'((h / CENTI_PER_SEC) % (`SW_MAX_SEC + 1));
        t.centi   = `SW_CENTI_W'(h % CENTI_PER_SEC);
        return t;
    endfunction

    function automatic string fmt_time(input stopwatch_pkg::sw_time_t t);
        return $sformatf("%0d:%02d.%02d", t.minutes, t.seconds, t.centi);
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////

    task automatic set_switches(input logic prog, input logic count_up, input logic minute);
        @(posedge clk);
        buttons.prog     <= prog;
        buttons.count_up <= count_up;
        buttons.minute   <= minute;
        repeat (4) @(posedge clk);
    endtask

    task automatic press(input logic [2:0] which);
        @(posedge clk);
        buttons.start_stop <= which[2];
        buttons.clear      <= which[1];
        buttons.inc        <= which[0];
        @(posedge clk);
        buttons.start_stop <= 1'b0;
        buttons.clear      <= 1'b0;
        buttons.inc        <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic give_tick();
        @(posedge clk);
        tick <= 1'b1;
        @(posedge clk);
        tick <= 1'b0;
    endtask

    task automatic run_ticks(input int n);
        for (int i = 0; i < n; i++) begin
            give_tick();
            repeat (take_bits(2)) @(posedge clk);   // Random idle gap
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic check_time(input string what, input stopwatch_pkg::sw_time_t want);
        @(negedge clk);
        checks++;
        assert (time_out == want) else begin
            $display("[ERROR] %s, %s: expected %s, actual %s",
                     cur_test, what, fmt_time(want), fmt_time(time_out));
            errors++;
        end
    endtask

    task automatic check_int(input string what, input int want, input int got);
        checks++;
        assert (got == want) else begin
            $display("[ERROR] %s, %s: expected %0d, actual %0d", cur_test, what, want, got);
            errors++;
        end
    endtask

    // Tick until expired shows or the tick limit is hit
    task automatic run_countdown(input int want_ticks);
        int ticks;
        int base;
        ticks = 0;
        base  = expired_count;
        while (expired_count == base && ticks < want_ticks + 20) begin
            give_tick();
            repeat (3) @(posedge clk);
            ticks++;
        end
        checks++;
        assert (expired_count != base) else begin
            $display("%s: the countdown gave no expiry within %0d ticks", cur_test, ticks);
            errors++;
        end
        check_int("ticks to expiry", want_ticks, ticks);
        check_time("time at expiry", '0);
        run_ticks(20);
        check_int("expiry pulses", 1, expired_count - base);
    endtask

    task automatic begin_test(input string name);
        cur_test          = name;
        test_start_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", cur_test, errors - test_start_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        stopwatch_pkg::sw_time_t want;
        int n;
        int mins;
        int secs;
        arst_n  <= 1'b0;
        tick    <= 1'b0;
        buttons <= '{start_stop: 1'b0, clear: 1'b0, inc: 1'b0,
                     prog: 1'b1, count_up: 1'b0, minute: 1'b0};
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        begin_test("reset");
        check_time("time after reset", '0);
        check_int("expired after reset", 0, int'(expired));
        end_test();

        begin_test("count_up");
        n = 6000 + take_bits(10);                  // Past the first minute carry
        set_switches(1'b0, 1'b1, 1'b0);
        press(PRESS_START);
        run_ticks(n);
        press(PRESS_START);
        want = to_time(n);
        check_time("time after run", want);
        run_ticks(50);
        check_time("time while stopped", want);
        press(PRESS_CLEAR);
        check_time("time after clear", '0);
        end_test();

        begin_test("programming");
        mins = `SW_MAX_MIN + 1 + take_bits(2);     // Past the minute limit
        secs = 1 + take_bits(5);                   // Below the second limit
        set_switches(1'b1, 1'b0, 1'b1);
        repeat (mins) press(PRESS_INC);
        set_switches(1'b1, 1'b0, 1'b0);
        repeat (secs) press(PRESS_INC);
        want = '0;
        want.minutes = `SW_MIN_W'((mins > `SW_MAX_MIN) ? `SW_MAX_MIN : mins);
        want.seconds = `SW_SEC_W'((secs > `SW_MAX_SEC) ? `SW_MAX_SEC : secs);
        check_time("programmed time", want);
        repeat (`SW_MAX_SEC) press(PRESS_INC);     // Seconds run into their limit too
        want.seconds = `SW_SEC_W'(`SW_MAX_SEC);
        check_time("saturated time", want);
        press(PRESS_CLEAR);
        check_time("time after clear", '0);
        end_test();

        begin_test("programmed_countdown");
        secs = 1 + take_bits(1);
        repeat (secs) press(PRESS_INC);            // Minute switch is low
        set_switches(1'b0, 1'b0, 1'b0);
        check_time("loaded time", to_time(secs * CENTI_PER_SEC));
        press(PRESS_START);
        run_countdown(secs * CENTI_PER_SEC);
        end_test();

        begin_test("default_countdown");
        set_switches(1'b1, 1'b0, 1'b0);
        press(PRESS_CLEAR);
        set_switches(1'b0, 1'b0, 1'b0);
        check_time("loaded time", to_time(DEFAULT_TICKS));
        press(PRESS_START);
        run_countdown(DEFAULT_TICKS);
        end_test();

        begin_test("mode_change");
        press(PRESS_CLEAR);                        // Reload the default time
        press(PRESS_START);
        run_ticks(100);
        check_time("time before switch", to_time(DEFAULT_TICKS - 100));
        n = expired_count;
        set_switches(1'b0, 1'b1, 1'b0);
        check_time("time after switch to up", '0);
        run_ticks(500);
        check_time("time after more ticks", '0);
        check_int("expiry pulses", n, expired_count);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
